/* rtl/preamble_pkg.sv */
package preamble_pkg;

    // One I or Q component at the fixed table scale, two's complement.
    typedef logic signed [9:0] sample_t;

    typedef logic [3:0] short_idx_t;                // Index into the 16-entry short table.
    typedef logic [5:0] long_idx_t;                 // Index into the 64-entry long table.

    localparam int SHORT_LEN    = 160;              // Ten repeats of the short symbol.
    localparam int SHORT_PERIOD = 16;
    localparam int LONG_GI_LEN  = 32;               // Second half of the long symbol.
    localparam int LONG_SYM_LEN = 64;

    // Whole burst: short part, guard interval and two long symbols.
    localparam int BURST_LEN    = SHORT_LEN + LONG_GI_LEN + 2 * LONG_SYM_LEN;

    // Burst segments walked by the sequencer.
    typedef enum logic [1:0] {
        IDLE,
        SHORT,
        LONG_GI,
        LONG_SYM
    } seq_state_t;

endpackage

/* rtl/pre_sequencer.sv */
`timescale 1ns/100ps

module pre_sequencer (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     start_i,
    output preamble_pkg::short_idx_t short_idx_o,
    output preamble_pkg::long_idx_t  long_idx_o,
    output logic                     active_o,
    output logic                     long_o,
    output logic                     first_o,
    output logic                     junction_o,
    output logic                     last_o
);

    preamble_pkg::seq_state_t state;                // Segment of the last issued position.
    preamble_pkg::seq_state_t state_nxt;
    logic [8:0]               pos;                  // Last issued burst position.
    logic [8:0]               pos_nxt;
    logic                     issue;                // A position is issued at this edge.

    always_comb begin
        state_nxt = state;
        pos_nxt   = pos + 9'd1;
        issue     = 1'b1;
        case (state)
            preamble_pkg::IDLE: begin
                pos_nxt = '0;
                issue   = start_i;                  // Only a start leaves IDLE.
                if (start_i) begin
                    state_nxt = preamble_pkg::SHORT;
                end
            end
            preamble_pkg::SHORT: begin
                if (pos == 9'(preamble_pkg::SHORT_LEN - 1)) begin
                    state_nxt = preamble_pkg::LONG_GI;
                end
            end
            preamble_pkg::LONG_GI: begin
                if (pos == 9'(preamble_pkg::SHORT_LEN + preamble_pkg::LONG_GI_LEN - 1)) begin
                    state_nxt = preamble_pkg::LONG_SYM;
                end
            end
            default: begin
                // Issuing position 319 already frees the FSM, so bursts can run back to back.
                if (pos == 9'(preamble_pkg::BURST_LEN - 2)) begin
                    state_nxt = preamble_pkg::IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state       <= preamble_pkg::IDLE;
            pos         <= '0;
            active_o    <= 1'b0;
            long_o      <= 1'b0;
            first_o     <= 1'b0;
            junction_o  <= 1'b0;
            last_o      <= 1'b0;
            short_idx_o <= '0;
            long_idx_o  <= '0;
        end else begin
            state      <= state_nxt;
            pos        <= pos_nxt;
            active_o   <= issue;
            long_o     <= issue && (pos_nxt >= 9'(preamble_pkg::SHORT_LEN));
            first_o    <= issue && (pos_nxt == 9'd0);
            junction_o <= issue && (pos_nxt == 9'(preamble_pkg::SHORT_LEN));
            last_o     <= issue && (pos_nxt == 9'(preamble_pkg::BURST_LEN - 1));
            // At position 160 this wraps to 0, the continuation of the short symbol.
            short_idx_o <= preamble_pkg::short_idx_t'(pos_nxt % preamble_pkg::SHORT_PERIOD);
            // Guard 160..191 maps to 32..63 and the symbols restart at 192, both p mod 64.
            long_idx_o  <= preamble_pkg::long_idx_t'(pos_nxt % preamble_pkg::LONG_SYM_LEN);
        end
    end

endmodule

/* rtl/tx_short_pre.sv */
`timescale 1ns/100ps

module tx_short_pre (
    input  preamble_pkg::short_idx_t index_i,
    output preamble_pkg::sample_t    out_i_o,
    output preamble_pkg::sample_t    out_q_o
);

    // Short training symbol, same scale as the long table.
    always_comb begin
        case (index_i)
            4'd00: {out_i_o, out_q_o} = {  10'd47,   10'd47};
            4'd01: {out_i_o, out_q_o} = {-10'd135,    10'd2};
            4'd02: {out_i_o, out_q_o} = { -10'd13,  -10'd81};
            4'd03: {out_i_o, out_q_o} = { 10'd146,  -10'd13};
            4'd04: {out_i_o, out_q_o} = {  10'd94,    10'd0};
            4'd05: {out_i_o, out_q_o} = { 10'd146,  -10'd13};
            4'd06: {out_i_o, out_q_o} = { -10'd13,  -10'd81};
            4'd07: {out_i_o, out_q_o} = {-10'd135,    10'd2};
            4'd08: {out_i_o, out_q_o} = {  10'd47,   10'd47};
            4'd09: {out_i_o, out_q_o} = {   10'd2, -10'd135};
            4'd10: {out_i_o, out_q_o} = { -10'd81,  -10'd13};
            4'd11: {out_i_o, out_q_o} = { -10'd13,  10'd146};
            4'd12: {out_i_o, out_q_o} = {   10'd0,   10'd94};
            4'd13: {out_i_o, out_q_o} = { -10'd13,  10'd146};
            4'd14: {out_i_o, out_q_o} = { -10'd81,  -10'd13};
            4'd15: {out_i_o, out_q_o} = {   10'd2, -10'd135};
            default: {out_i_o, out_q_o} = {10'd0, 10'd0};
        endcase
    end

endmodule

/* rtl/tx_long_pre.sv */
`timescale 1ns/100ps

module tx_long_pre (
    input  preamble_pkg::long_idx_t index_i,        // 0 to 63.
    output preamble_pkg::sample_t   out_i_o,
    output preamble_pkg::sample_t   out_q_o
);

    always_comb begin
        case (index_i)
            6'd00: {out_i_o, out_q_o} = { 10'd160,    10'd0};
            6'd01: {out_i_o, out_q_o} = {  -10'd5, -10'd123};
            6'd02: {out_i_o, out_q_o} = {  10'd41, -10'd114};
            6'd03: {out_i_o, out_q_o} = {  10'd99,   10'd85};
            6'd04: {out_i_o, out_q_o} = {  10'd22,   10'd29};
            6'd05: {out_i_o, out_q_o} = {  10'd61,  -10'd90};
            6'd06: {out_i_o, out_q_o} = {-10'd118,  -10'd57};
            6'd07: {out_i_o, out_q_o} = { -10'd39, -10'd109};
            6'd08: {out_i_o, out_q_o} = { 10'd100,  -10'd27};
            6'd09: {out_i_o, out_q_o} = {  10'd55,    10'd4};
            6'd10: {out_i_o, out_q_o} = {   10'd1, -10'd118};
            6'd11: {out_i_o, out_q_o} = {-10'd140,  -10'd49};
            6'd12: {out_i_o, out_q_o} = {  10'd25,  -10'd60};
            6'd13: {out_i_o, out_q_o} = {  10'd60,  -10'd15};
            6'd14: {out_i_o, out_q_o} = { -10'd23,  10'd165};
            6'd15: {out_i_o, out_q_o} = { 10'd122,   -10'd4};
            6'd16: {out_i_o, out_q_o} = {  10'd64,  -10'd64};
            6'd17: {out_i_o, out_q_o} = {  10'd38,  10'd101};
            6'd18: {out_i_o, out_q_o} = { -10'd59,   10'd40};
            6'd19: {out_i_o, out_q_o} = {-10'd134,   10'd67};
            6'd20: {out_i_o, out_q_o} = {  10'd84,   10'd95};
            6'd21: {out_i_o, out_q_o} = {  10'd71,   10'd14};
            6'd22: {out_i_o, out_q_o} = { -10'd62,   10'd83};
            6'd23: {out_i_o, out_q_o} = { -10'd58,  -10'd22};
            6'd24: {out_i_o, out_q_o} = { -10'd36, -10'd155};
            6'd25: {out_i_o, out_q_o} = {-10'd125,  -10'd17};
            6'd26: {out_i_o, out_q_o} = {-10'd130,  -10'd21};
            6'd27: {out_i_o, out_q_o} = {  10'd77,  -10'd76};
            6'd28: {out_i_o, out_q_o} = {  -10'd3,   10'd55};
            6'd29: {out_i_o, out_q_o} = { -10'd94,  10'd118};
            6'd30: {out_i_o, out_q_o} = {  10'd94,  10'd108};
            6'd31: {out_i_o, out_q_o} = {  10'd13,  10'd100};
            // Second half, also used as the guard interval.
            6'd32: {out_i_o, out_q_o} = {-10'd160,    10'd0};
            6'd33: {out_i_o, out_q_o} = {  10'd13, -10'd100};
            6'd34: {out_i_o, out_q_o} = {  10'd94, -10'd108};
            6'd35: {out_i_o, out_q_o} = { -10'd94, -10'd118};
            6'd36: {out_i_o, out_q_o} = {  -10'd3,  -10'd55};
            6'd37: {out_i_o, out_q_o} = {  10'd77,   10'd76};
            6'd38: {out_i_o, out_q_o} = {-10'd130,   10'd21};
            6'd39: {out_i_o, out_q_o} = {-10'd125,   10'd17};
            6'd40: {out_i_o, out_q_o} = { -10'd36,  10'd155};
            6'd41: {out_i_o, out_q_o} = { -10'd58,   10'd22};
            6'd42: {out_i_o, out_q_o} = { -10'd62,  -10'd83};
            6'd43: {out_i_o, out_q_o} = {  10'd71,  -10'd14};
            6'd44: {out_i_o, out_q_o} = {  10'd84,  -10'd95};
            6'd45: {out_i_o, out_q_o} = {-10'd134,  -10'd67};
            6'd46: {out_i_o, out_q_o} = { -10'd59,  -10'd40};
            6'd47: {out_i_o, out_q_o} = {  10'd38, -10'd101};
            6'd48: {out_i_o, out_q_o} = {  10'd64,   10'd64};
            6'd49: {out_i_o, out_q_o} = { 10'd122,    10'd4};
            6'd50: {out_i_o, out_q_o} = { -10'd23, -10'd165};
            6'd51: {out_i_o, out_q_o} = {  10'd60,   10'd15};
            6'd52: {out_i_o, out_q_o} = {  10'd25,   10'd60};
            6'd53: {out_i_o, out_q_o} = {-10'd140,   10'd49};
            6'd54: {out_i_o, out_q_o} = {   10'd1,  10'd118};
            6'd55: {out_i_o, out_q_o} = {  10'd55,   -10'd4};
            6'd56: {out_i_o, out_q_o} = { 10'd100,   10'd27};
            6'd57: {out_i_o, out_q_o} = { -10'd39,  10'd109};
            6'd58: {out_i_o, out_q_o} = {-10'd118,   10'd57};
            6'd59: {out_i_o, out_q_o} = {  10'd61,   10'd90};
            6'd60: {out_i_o, out_q_o} = {  10'd22,  -10'd29};
            6'd61: {out_i_o, out_q_o} = {  10'd99,  -10'd85};
            6'd62: {out_i_o, out_q_o} = {  10'd41,  10'd114};
            6'd63: {out_i_o, out_q_o} = {  -10'd5,  10'd123};
            default: {out_i_o, out_q_o} = {10'd0, 10'd0};
        endcase
    end

endmodule

/* rtl/pre_output.sv */
`timescale 1ns/100ps

module pre_output (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  active_i,
    input  logic                  long_i,
    input  logic                  first_i,
    input  logic                  junction_i,
    input  logic                  last_i,
    input  preamble_pkg::sample_t short_i_i,
    input  preamble_pkg::sample_t short_q_i,
    input  preamble_pkg::sample_t long_i_i,
    input  preamble_pkg::sample_t long_q_i,
    output preamble_pkg::sample_t sample_i_o,
    output preamble_pkg::sample_t sample_q_o,
    output logic                  valid_o,
    output logic                  done_o
);

    preamble_pkg::sample_t sel_i;
    preamble_pkg::sample_t sel_q;
    preamble_pkg::sample_t win_i;
    preamble_pkg::sample_t win_q;
    logic signed [10:0]    sum_i;                   // Junction sums keep the carry bit.
    logic signed [10:0]    sum_q;

    assign sel_i = long_i ? long_i_i : short_i_i;
    assign sel_q = long_i ? long_q_i : short_q_i;

    assign sum_i = 11'(short_i_i) + 11'(long_i_i);
    assign sum_q = 11'(short_q_i) + 11'(long_q_i);

    // Two-point window at the burst start and at the short to long junction.
    always_comb begin
        if (junction_i) begin
            win_i = sum_i[10:1];                    // Average of both tables.
            win_q = sum_q[10:1];
        end else if (first_i) begin
            win_i = sel_i >>> 1;                    // Ramp in from zero.
            win_q = sel_q >>> 1;
        end else begin
            win_i = sel_i;
            win_q = sel_q;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sample_i_o <= '0;
            sample_q_o <= '0;
            valid_o    <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            valid_o <= active_i;
            done_o  <= active_i && last_i;          // Pulses with the last sample.
            if (active_i) begin
                sample_i_o <= win_i;
                sample_q_o <= win_q;
            end else begin
                sample_i_o <= '0;                   // Outputs idle at zero between bursts.
                sample_q_o <= '0;
            end
        end
    end

endmodule

/* rtl/preamble_gen.sv */
`timescale 1ns/100ps

module preamble_gen (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  start_i,
    output preamble_pkg::sample_t sample_i_o,
    output preamble_pkg::sample_t sample_q_o,
    output logic                  valid_o,
    output logic                  done_o
);

    preamble_pkg::short_idx_t short_idx;
    preamble_pkg::long_idx_t  long_idx;
    logic                     seq_active;
    logic                     seq_long;
    logic                     seq_first;
    logic                     seq_junction;
    logic                     seq_last;
    preamble_pkg::sample_t    short_smp_i;
    preamble_pkg::sample_t    short_smp_q;
    preamble_pkg::sample_t    long_smp_i;
    preamble_pkg::sample_t    long_smp_q;

    pre_sequencer u_seq (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .start_i     (start_i),
        .short_idx_o (short_idx),
        .long_idx_o  (long_idx),
        .active_o    (seq_active),
        .long_o      (seq_long),
        .first_o     (seq_first),
        .junction_o  (seq_junction),
        .last_o      (seq_last)
    );

    tx_short_pre u_short (
        .index_i (short_idx),
        .out_i_o (short_smp_i),
        .out_q_o (short_smp_q)
    );

    tx_long_pre u_long (
        .index_i (long_idx),
        .out_i_o (long_smp_i),
        .out_q_o (long_smp_q)
    );

    pre_output u_out (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .active_i   (seq_active),
        .long_i     (seq_long),
        .first_i    (seq_first),
        .junction_i (seq_junction),
        .last_i     (seq_last),
        .short_i_i  (short_smp_i),
        .short_q_i  (short_smp_q),
        .long_i_i   (long_smp_i),
        .long_q_i   (long_smp_q),
        .sample_i_o (sample_i_o),
        .sample_q_o (sample_q_o),
        .valid_o    (valid_o),
        .done_o     (done_o)
    );

endmodule

/* tests/preamble_ref.svh */
`ifndef PREAMBLE_REF_SVH
`define PREAMBLE_REF_SVH

// Short training symbol at the scale of the long table.
localparam int SHORT_I [16] = '{47, -135, -13, 146, 94, 146, -13, -135,
                                47, 2, -81, -13, 0, -13, -81, 2};
localparam int SHORT_Q [16] = '{47, 2, -81, -13, 0, -13, -81, 2,
                                47, -135, -13, 146, 94, 146, -13, -135};

// Long training symbol with entries 0 to 63.
localparam int LONG_I [64] = '{160, -5, 41, 99, 22, 61, -118, -39,
                               100, 55, 1, -140, 25, 60, -23, 122,
                               64, 38, -59, -134, 84, 71, -62, -58,
                               -36, -125, -130, 77, -3, -94, 94, 13,
                               -160, 13, 94, -94, -3, 77, -130, -125,
                               -36, -58, -62, 71, 84, -134, -59, 38,
                               64, 122, -23, 60, 25, -140, 1, 55,
                               100, -39, -118, 61, 22, 99, 41, -5};
localparam int LONG_Q [64] = '{0, -123, -114, 85, 29, -90, -57, -109,
                               -27, 4, -118, -49, -60, -15, 165, -4,
                               -64, 101, 40, 67, 95, 14, 83, -22,
                               -155, -17, -21, -76, 55, 118, 108, 100,
                               0, -100, -108, -118, -55, 76, 21, 17,
                               155, 22, -83, -14, -95, -67, -40, -101,
                               64, 4, -165, 15, 60, 49, 118, -4,
                               27, 109, 57, 90, -29, -85, 114, 123};

// Expected I and Q at burst position pos with the edge windowing applied.
function automatic void expected_sample(input int pos,
                                        output preamble_pkg::sample_t exp_i,
                                        output preamble_pkg::sample_t exp_q);
    int short_idx;
    int long_idx;
    int val_i;
    int val_q;
    short_idx = pos % preamble_pkg::SHORT_PERIOD;
    if (pos < preamble_pkg::SHORT_LEN) begin
        long_idx = 0;                               // Long table unused here.
    end else if (pos < preamble_pkg::SHORT_LEN + preamble_pkg::LONG_GI_LEN) begin
        long_idx = pos - 128;                       // The guard covers entries 32 to 63.
    end else begin
        long_idx = (pos - 192) % preamble_pkg::LONG_SYM_LEN;
    end
    if (pos == 0) begin
        val_i = SHORT_I[short_idx] >>> 1;
        val_q = SHORT_Q[short_idx] >>> 1;
    end else if (pos == preamble_pkg::SHORT_LEN) begin
        val_i = (SHORT_I[short_idx] + LONG_I[long_idx]) >>> 1;
        val_q = (SHORT_Q[short_idx] + LONG_Q[long_idx]) >>> 1;
    end else if (pos < preamble_pkg::SHORT_LEN) begin
        val_i = SHORT_I[short_idx];
        val_q = SHORT_Q[short_idx];
    end else begin
        val_i = LONG_I[long_idx];
        val_q = LONG_Q[long_idx];
    end
    exp_i = preamble_pkg::sample_t'(val_i);
    exp_q = preamble_pkg::sample_t'(val_q);
endfunction

`endif

/* tests/preamble_gen_tb.sv */
`timescale 1ns/100ps

module preamble_gen_tb;

    `include "preamble_ref.svh"

    logic                  clk;
    logic                  rst_n;
    logic                  start;
    preamble_pkg::sample_t out_i;
    preamble_pkg::sample_t out_q;
    logic                  valid;
    logic                  done;

    integer                seed;                    // Drives the gaps between bursts.
    int                    error_count;
    int                    check_count;
    int                    sample_count;            // Burst position of the next sample.
    int                    burst_count;
    int                    expected_bursts;
    int                    gap;
    logic                  monitor_en;
    preamble_pkg::sample_t cap_i [preamble_pkg::BURST_LEN];
    preamble_pkg::sample_t cap_q [preamble_pkg::BURST_LEN];

    preamble_gen DUT (
        .clk        (clk),
        .rst_n_i    (rst_n),
        .start_i    (start),
        .sample_i_o (out_i),
        .sample_q_o (out_q),
        .valid_o    (valid),
        .done_o     (done)
    );

    always #20 clk = ~clk;

    task automatic compare_sample(input string name, input int pos,
                                  input preamble_pkg::sample_t actual,
                                  input preamble_pkg::sample_t expected);
        string where_s;
        where_s = (pos < 0) ? "while idle" : $sformatf("at position %0d", pos);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("mismatch %s %s: expected %h, actual %h", name, where_s, expected, actual);
        end
    endtask

    // Period 16 in the short part, and the guard and second symbol repeat the long symbol.
    task automatic verify_structure();
        int bad;
        bad = 0;
        for (int p = 1; p < 144; p++) begin
            if (cap_i[p] !== cap_i[p + 16] || cap_q[p] !== cap_q[p + 16]) begin
                bad++;
            end
        end
        for (int p = 161; p < 192; p++) begin
            if (cap_i[p] !== cap_i[p + 128] || cap_q[p] !== cap_q[p + 128]) begin
                bad++;
            end
        end
        for (int p = 192; p < 256; p++) begin
            if (cap_i[p] !== cap_i[p + 64] || cap_q[p] !== cap_q[p + 64]) begin
                bad++;
            end
        end
        check_count++;
        assert (bad == 0) else begin
            error_count++;
            $display("burst %0d breaks the preamble structure at %0d positions", burst_count, bad);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("checks: %0d, errors: %0d", check_count, error_count + 1);
        $display("Some tests failed");
        $finish;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // Start from idle; valid must rise at the second edge after the one that raised start.
    task automatic start_and_check_latency();
        pulse_start();
        expected_bursts++;
        @(negedge clk);
        check_count++;
        assert (!valid) else begin
            error_count++;
            $display("valid_o rose one cycle after start_i, two cycles expected");
        end
        @(negedge clk);
        check_count++;
        assert (valid) else begin
            error_count++;
            $display("valid_o did not rise two cycles after start_i");
        end
    endtask

    task automatic wait_for_done(input int limit);
        int cycles;
        cycles = 0;
        while (!done && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            abort_run($sformatf("timeout: done_o did not pulse within %0d cycles", limit));
        end
    endtask

    always @(negedge clk) begin
        preamble_pkg::sample_t exp_i;
        preamble_pkg::sample_t exp_q;
        logic                  exp_done;
        if (monitor_en) begin
            if (valid) begin
                check_count++;
                assert (sample_count < preamble_pkg::BURST_LEN) else begin
                    error_count++;
                    $display("valid_o stayed high beyond %0d samples", preamble_pkg::BURST_LEN);
                end
                if (sample_count < preamble_pkg::BURST_LEN) begin
                    expected_sample(sample_count, exp_i, exp_q);
                    cap_i[sample_count] = out_i;
                    cap_q[sample_count] = out_q;
                    compare_sample("sample_i_o", sample_count, out_i, exp_i);
                    compare_sample("sample_q_o", sample_count, out_q, exp_q);
                end
                exp_done = (sample_count == preamble_pkg::BURST_LEN - 1);
                check_count++;
                assert (done == exp_done) else begin
                    error_count++;
                    $display("mismatch done_o at position %0d: expected %h, actual %h",
                             sample_count, exp_done, done);
                end
                if (done && exp_done) begin
                    verify_structure();
                end
                if (done) begin
                    burst_count++;
                    sample_count = 0;
                end else begin
                    sample_count++;
                end
            end else begin
                check_count++;
                assert (sample_count == 0) else begin
                    error_count++;
                    $display("valid_o dropped after %0d of %0d samples", sample_count,
                             preamble_pkg::BURST_LEN);
                end
                sample_count = 0;
                check_count++;
                assert (!done) else begin
                    error_count++;
                    $display("done_o pulsed while valid_o was low");
                end
                compare_sample("sample_i_o", -1, out_i, '0);
                compare_sample("sample_q_o", -1, out_q, '0);
            end
        end
    end

    initial begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        start           = 1'b0;
        seed            = 83738;
        error_count     = 0;
        check_count     = 0;
        sample_count    = 0;
        burst_count     = 0;
        expected_bursts = 0;
        monitor_en      = 1'b0;

        @(posedge clk);
        monitor_en = 1'b1;                          // Reset state is checked from here on.
        repeat (9) @(posedge clk);
        rst_n <= 1'b1;
        repeat (6) @(posedge clk);

        // Single burst from idle.
        start_and_check_latency();
        wait_for_done(preamble_pkg::BURST_LEN + 8);
        repeat (5) @(posedge clk);

        // A second start in the middle of a burst must be ignored.
        start_and_check_latency();
        repeat (120) @(posedge clk);
        pulse_start();
        wait_for_done(preamble_pkg::BURST_LEN + 8);
        repeat (20) @(posedge clk);

        for (int b = 0; b < 3; b++) begin
            gap = 1 + ($random(seed) & 15);
            repeat (gap) @(posedge clk);
            start_and_check_latency();
            wait_for_done(preamble_pkg::BURST_LEN + 8);
        end

        // The back-to-back start is sampled at the edge that raises done_o.
        start_and_check_latency();
        repeat (317) @(negedge clk);
        pulse_start();
        expected_bursts++;
        repeat (2) begin
            @(negedge clk);
            check_count++;
            assert (valid) else begin
                error_count++;
                $display("valid_o dropped between back-to-back bursts");
            end
        end
        wait_for_done(preamble_pkg::BURST_LEN + 8);

        gap = 1 + ($random(seed) & 15);
        repeat (gap) @(posedge clk);
        start_and_check_latency();
        wait_for_done(preamble_pkg::BURST_LEN + 8);
        repeat (10) @(posedge clk);

        check_count++;
        assert (burst_count == expected_bursts) else begin
            error_count++;
            $display("saw %0d bursts where %0d were started", burst_count, expected_bursts);
        end
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+tests
rtl/preamble_pkg.sv
rtl/pre_sequencer.sv
rtl/tx_short_pre.sv
rtl/tx_long_pre.sv
rtl/pre_output.sv
rtl/preamble_gen.sv
tests/preamble_gen_tb.sv

/* run.sh */
#!/bin/sh
# Builds the preamble generator testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sources.f \
    --top-module preamble_gen_tb \
    --Mdir obj_dir \
    -o preamble_sim

./obj_dir/preamble_sim | tee sim.log

if grep -q "All tests passed" sim.log; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED"
    exit 1
fi
